//--- verilog.f
+incdir+hw
hw/exec_pkg.sv
hw/alu_unit.sv
hw/shift_unit.sv
hw/branch_unit.sv
hw/lsu_unit.sv
hw/execute.sv
testbench/tb_execute.sv

//--- testbench/tb_execute.sv
`default_nettype none

`include "exec_settings.svh"

module tb_execute;
    timeunit 1ns;
    timeprecision 100ps;

    import exec_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 2;     // Inputs change after the edge
    localparam int SAMPLE_DELAY   = 1;     // Outputs settled by then
    localparam int RESET_CYCLES   = 4;
    localparam int SEED           = 50649;
    localparam int TEST_CYCLES    = 200;   // Rough total of all tests
    localparam int TIMEOUT_CYCLES = 10 * TEST_CYCLES;

    logic      clk;
    logic      rst;
    logic      stall;
    exec_in_t  in_drv;
    exec_out_t out_o;
    mem_req_t  mem_o;

    exec_out_t last_out;                   // Expected outputs of the newest instruction
    mem_req_t  last_mem;
    int        checks;
    int        errors;
    int        cycle_count;

    execute dut (
        .clk     (clk),
        .rst_i   (rst),
        .stall_i (stall),
        .in_i    (in_drv),
        .out_o   (out_o),
        .mem_o   (mem_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic load_op(input exec_op_e op);
        return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    endfunction

    function automatic logic access_misaligned(input exec_in_t x);
        logic [31:0] addr;
        addr = x.first_op + x.second_op;
        if (x.iop.op inside {OP_LH, OP_LHU, OP_SH})
            return addr[0];
        if (x.iop.op inside {OP_LW, OP_SW})
            return addr[1:0] != 2'b00;
        return 1'b0;
    endfunction

    function automatic exec_out_t expected_out(input exec_in_t x);
        exec_out_t   e;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [4:0]  sh;
        logic [31:0] addr;
        a    = x.first_op;
        b    = x.second_op;
        c    = x.third_op;
        sh   = b[4:0];
        addr = a + b;
        e.instruction      = x.instruction;
        e.pc               = x.pc;
        e.iop              = x.iop;
        e.tag              = x.tag;
        e.predicted_branch = x.predicted_branch;
        e.exception        = x.exception
                             || (x.iop.unit == MEMORY_UNIT && access_misaligned(x));
        e.result0          = b;            // Bypass and CSR
        e.result1          = '0;
        e.jump             = 1'b0;
        e.write_enable     = 1'b1;
        case (x.iop.unit)
            ALU_UNIT: begin
                case (x.iop.op)
                    OP_ADD:  e.result0 = a + b;
                    OP_SUB:  e.result0 = a - b;
                    OP_SLT:  e.result0 = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    OP_SLTU: e.result0 = (a < b) ? 32'd1 : 32'd0;
                    OP_XOR:  e.result0 = a ^ b;
                    OP_OR:   e.result0 = a | b;
                    OP_AND:  e.result0 = a & b;
                    default: e.result0 = '0;
                endcase
            end
            SHIFT_UNIT: begin
                case (x.iop.op)
                    OP_SLL:  e.result0 = a << sh;
                    OP_SRL:  e.result0 = a >> sh;
                    OP_SRA:  e.result0 = (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : '0);
                    default: e.result0 = '0;
                endcase
            end
            BRANCH_UNIT: begin
                e.result0 = x.pc + 32'd4;
                e.result1 = (x.iop.op == OP_JALR) ? ((a + c) & 32'hFFFF_FFFE) : x.pc + c;
                case (x.iop.op)
                    OP_BEQ:  e.jump = a == b;
                    OP_BNE:  e.jump = a != b;
                    OP_BLT:  e.jump = $signed(a) < $signed(b);
                    OP_BGE:  e.jump = $signed(a) >= $signed(b);
                    OP_BLTU: e.jump = a < b;
                    OP_BGEU: e.jump = a >= b;
                    default: e.jump = 1'b1;
                endcase
                e.write_enable = x.iop.op inside {OP_JAL, OP_JALR};
            end
            MEMORY_UNIT: begin
                e.result0      = c << (8 * addr[1:0]);
                e.result1      = addr & 32'hFFFF_FFFC;
                e.write_enable = load_op(x.iop.op);
            end
            default: ;
        endcase
        return e;
    endfunction

    function automatic mem_req_t expected_mem(input exec_in_t x);
        mem_req_t    m;
        logic [31:0] addr;
        logic        valid;
        addr  = x.first_op + x.second_op;
        valid = x.iop.unit == MEMORY_UNIT && !access_misaligned(x);
        m.read_address = addr;             // Not gated by the unit
        m.read         = valid && load_op(x.iop.op);
        m.write_strobe = '0;
        if (valid) begin
            case (x.iop.op)
                OP_SB:   m.write_strobe = 4'b0001 << addr[1:0];
                OP_SH:   m.write_strobe = 4'b0011 << addr[1:0];
                OP_SW:   m.write_strobe = 4'b1111;
                default: m.write_strobe = '0;
            endcase
        end
        return m;
    endfunction

    ////////////////////
    // Drive and check
    ////////////////////

    function automatic exec_in_t build_instr(input exec_unit_e unit, input exec_op_e op,
                                             input logic [31:0] a, input logic [31:0] b,
                                             input logic [31:0] c);
        exec_in_t    x;
        logic [31:0] extra;
        extra              = $urandom;
        x.instruction      = $urandom;
        x.pc               = $urandom & 32'hFFFF_FFFC;
        x.first_op         = a;
        x.second_op        = b;
        x.third_op         = c;
        x.iop.unit         = unit;
        x.iop.op           = op;
        x.tag              = extra[`EXEC_TAG_W-1:0];
        x.predicted_branch = extra[31];
        x.exception        = 1'b0;
        return x;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        checks = checks + 1;
        assert (actual === expected)
        else begin
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
            errors = errors + 1;
        end
    endtask

    task automatic check_outputs(input exec_out_t eo, input mem_req_t em);
        compare_value("out_o.instruction", out_o.instruction, eo.instruction);
        compare_value("out_o.pc", out_o.pc, eo.pc);
        compare_value("out_o.iop", out_o.iop, eo.iop);
        compare_value("out_o.tag", out_o.tag, eo.tag);
        compare_value("out_o.predicted_branch", out_o.predicted_branch, eo.predicted_branch);
        compare_value("out_o.exception", out_o.exception, eo.exception);
        compare_value("out_o.result0", out_o.result0, eo.result0);
        compare_value("out_o.result1", out_o.result1, eo.result1);
        compare_value("out_o.jump", out_o.jump, eo.jump);
        compare_value("out_o.write_enable", out_o.write_enable, eo.write_enable);
        compare_value("mem_o.read", mem_o.read, em.read);
        compare_value("mem_o.read_address", mem_o.read_address, em.read_address);
        compare_value("mem_o.write_strobe", mem_o.write_strobe, em.write_strobe);
    endtask

    // Called at DRIVE_DELAY after an edge, returns at the same point one cycle later
    task automatic issue(input exec_in_t x);
        in_drv   = x;
        last_out = expected_out(x);
        last_mem = expected_mem(x);
        @(posedge clk);
        #SAMPLE_DELAY;
        check_outputs(last_out, last_mem);
        #(DRIVE_DELAY - SAMPLE_DELAY);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        $display("%-14s %s (%0d errors)", name,
                 (errors == errors_before) ? "ok" : "FAIL", errors - errors_before);
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic check_reset();
        int        start;
        exec_out_t zero_out;
        mem_req_t  zero_mem;
        start       = errors;
        zero_out    = '0;
        zero_out.pc = `EXEC_RESET_PC;
        zero_mem    = '0;
        check_outputs(zero_out, zero_mem);
        finish_test("reset", start);
    endtask

    task automatic exercise_alu();
        int       start;
        exec_op_e alu_ops [7] = '{OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_XOR, OP_OR, OP_AND};
        start = errors;
        for (int i = 0; i < 40; i++)
            issue(build_instr(ALU_UNIT, alu_ops[i % 7], $urandom, $urandom, $urandom));
        for (int i = 0; i < 2; i++) begin
            issue(build_instr(BYPASS_UNIT, exec_op_e'(i), $urandom, $urandom, $urandom));
            issue(build_instr(CSR_UNIT, exec_op_e'(i), $urandom, $urandom, $urandom));
        end
        finish_test("alu_bypass", start);
    endtask

    task automatic sweep_shifts();
        int          start;
        logic [31:0] value;
        logic [4:0]  amount;
        exec_op_e    shift_ops [3] = '{OP_SLL, OP_SRL, OP_SRA};
        start = errors;
        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < 4; j++) begin
                for (int s = 0; s < 3; s++) begin
                    value  = $urandom;
                    value[31] = j[0];              // Odd rounds use negative values
                    amount = (s == 0) ? 5'd0 : (s == 1) ? 5'd31 : 5'($urandom);
                    issue(build_instr(SHIFT_UNIT, shift_ops[k], value,
                                      ($urandom & 32'hFFFF_FFE0) | amount, $urandom));
                end
            end
        end
        finish_test("shifts", start);
    endtask

    task automatic branch_conditions();
        int          start;
        logic [31:0] offset;
        exec_op_e    cond_ops [6] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
        logic [31:0] lhs [5] = '{32'd5, 32'hFFFF_FFFD, 32'd7, 32'd2, 32'd9};
        logic [31:0] rhs [5] = '{32'd5, 32'd7, 32'hFFFF_FFFD, 32'd9, 32'd2};
        start = errors;
        for (int k = 0; k < 6; k++) begin
            for (int p = 0; p < 5; p++) begin
                offset = $urandom & 32'hFFFF_FFFE;
                issue(build_instr(BRANCH_UNIT, cond_ops[k], lhs[p], rhs[p], offset));
            end
        end
        for (int i = 0; i < 3; i++) begin
            issue(build_instr(BRANCH_UNIT, OP_JAL, $urandom, $urandom,
                              $urandom & 32'hFFFF_FFFE));
            issue(build_instr(BRANCH_UNIT, OP_JALR, $urandom & 32'hFFFF_FFFE, $urandom,
                              $urandom | 32'd1));      // Odd sum must lose bit 0
        end
        finish_test("branches", start);
    endtask

    task automatic memory_accesses();
        int          start;
        exec_in_t    x;
        exec_op_e    mem_ops [8] = '{OP_LB, OP_LH, OP_LW, OP_LBU,
                                     OP_LHU, OP_SB, OP_SH, OP_SW};
        start = errors;
        for (int k = 0; k < 8; k++) begin
            for (int off = 0; off < 4; off++)
                issue(build_instr(MEMORY_UNIT, mem_ops[k], $urandom & 32'hFFFF_FFFC,
                                  (($urandom % 64) << 2) + off, $urandom));
        end
        x = build_instr(MEMORY_UNIT, OP_LW, 32'h0000_1000, 32'h0000_0020, $urandom);
        x.exception = 1'b1;
        issue(x);
        x = build_instr(ALU_UNIT, OP_ADD, $urandom, $urandom, $urandom);
        x.exception = 1'b1;
        issue(x);
        finish_test("loads_stores", start);
    endtask

    task automatic stall_and_pipeline();
        int start;
        start = errors;
        for (int i = 0; i < 3; i++)
            issue(build_instr(ALU_UNIT, OP_XOR, $urandom, $urandom, $urandom));
        stall = 1'b1;
        for (int i = 0; i < 3; i++) begin
            in_drv = build_instr(MEMORY_UNIT, OP_SW, $urandom, $urandom, $urandom);
            @(posedge clk);
            #SAMPLE_DELAY;
            check_outputs(last_out, last_mem);  // Outputs frozen on the last result
            #(DRIVE_DELAY - SAMPLE_DELAY);
        end
        stall = 1'b0;
        issue(build_instr(ALU_UNIT, OP_SUB, $urandom, $urandom, $urandom));
        issue(build_instr(SHIFT_UNIT, OP_SRA, $urandom, $urandom, $urandom));
        finish_test("stall", start);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        void'($urandom(SEED));
        checks      = 0;
        errors      = 0;
        cycle_count = 0;
        rst         = 1'b1;
        stall       = 1'b0;
        in_drv      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        check_reset();
        exercise_alu();
        sweep_shifts();
        branch_conditions();
        memory_accesses();
        stall_and_pipeline();

        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, errors, cycle_count);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/execute.sv
`default_nettype none

`include "exec_settings.svh"

module execute (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                stall_i,
    input  exec_pkg::exec_in_t  in_i,
    output exec_pkg::exec_out_t out_o,
    output exec_pkg::mem_req_t  mem_o
);
    import exec_pkg::*;

    exec_unit_e            unit;
    exec_op_e              op;

    logic [`EXEC_XLEN-1:0] alu_result;
    logic [`EXEC_XLEN-1:0] shift_result;
    logic [`EXEC_XLEN-1:0] bypass_value;

    logic [`EXEC_XLEN-1:0] branch_link;
    logic [`EXEC_XLEN-1:0] branch_target;
    logic                  branch_jump;
    logic                  branch_we;

    logic                  lsu_enable;
    mem_req_t              lsu_req;
    logic [`EXEC_XLEN-1:0] lsu_address;
    logic [`EXEC_XLEN-1:0] lsu_data;
    logic                  lsu_we;
    logic                  lsu_misaligned;

    exec_out_t             out_next;

    ////////////////////
    // Dispatch
    ////////////////////

    assign unit         = in_i.iop.unit;
    assign op           = in_i.iop.op;
    assign lsu_enable   = unit == MEMORY_UNIT;        // Gates read, strobes and misalignment
    assign bypass_value = in_i.second_op;

    alu_unit u_alu (
        .a_i      (in_i.first_op),
        .b_i      (in_i.second_op),
        .op_i     (op),
        .result_o (alu_result)
    );

    shift_unit u_shift (
        .a_i      (in_i.first_op),
        .shamt_i  (in_i.second_op[4:0]),
        .op_i     (op),
        .result_o (shift_result)
    );

    branch_unit u_branch (
        .a_i            (in_i.first_op),
        .b_i            (in_i.second_op),
        .offset_i       (in_i.third_op),
        .pc_i           (in_i.pc),
        .op_i           (op),
        .link_o         (branch_link),
        .target_o       (branch_target),
        .jump_o         (branch_jump),
        .write_enable_o (branch_we)
    );

    lsu_unit u_lsu (
        .a_i             (in_i.first_op),
        .b_i             (in_i.second_op),
        .data_i          (in_i.third_op),
        .op_i            (op),
        .enable_i        (lsu_enable),
        .req_o           (lsu_req),
        .write_address_o (lsu_address),
        .write_data_o    (lsu_data),
        .write_enable_o  (lsu_we),
        .misaligned_o    (lsu_misaligned)
    );

    ////////////////////
    // Result demux
    ////////////////////

    always_comb begin
        out_next.instruction      = in_i.instruction;
        out_next.pc               = in_i.pc;
        out_next.iop              = in_i.iop;
        out_next.tag              = in_i.tag;
        out_next.predicted_branch = in_i.predicted_branch;
        out_next.exception        = in_i.exception || lsu_misaligned;

        // Bypass and CSR codes fall through these defaults
        out_next.result0      = bypass_value;
        out_next.result1      = '0;
        out_next.jump         = 1'b0;
        out_next.write_enable = 1'b1;

        case (unit)
            ALU_UNIT:   out_next.result0 = alu_result;
            SHIFT_UNIT: out_next.result0 = shift_result;
            BRANCH_UNIT: begin
                out_next.result0      = branch_link;
                out_next.result1      = branch_target;
                out_next.jump         = branch_jump;
                out_next.write_enable = branch_we;
            end
            MEMORY_UNIT: begin
                out_next.result0      = lsu_data;      // Lane-shifted store data
                out_next.result1      = lsu_address;   // Word-aligned write address
                out_next.write_enable = lsu_we;
            end
            default: ;
        endcase
    end

    ////////////////////
    // Output registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_o    <= '0;
            out_o.pc <= `EXEC_RESET_PC;
            mem_o    <= '0;
        end else if (!stall_i) begin
            out_o <= out_next;
            mem_o <= lsu_req;        // Already gated inside the LSU
        end
    end

    // A taken jump can only come from a registered branch instruction
    jump_from_branch: assert property (@(posedge clk) disable iff (rst_i)
        out_o.jump |-> (out_o.iop.unit == BRANCH_UNIT))
        else $error("execute: jump set for unit %0d", out_o.iop.unit);

endmodule

`default_nettype wire

//--- hw/lsu_unit.sv
`default_nettype none

`include "exec_settings.svh"

module lsu_unit (
    input  logic [`EXEC_XLEN-1:0] a_i,
    input  logic [`EXEC_XLEN-1:0] b_i,
    input  logic [`EXEC_XLEN-1:0] data_i,          // Store data, unaligned
    input  exec_pkg::exec_op_e    op_i,
    input  logic                  enable_i,
    output exec_pkg::mem_req_t    req_o,
    output logic [`EXEC_XLEN-1:0] write_address_o,
    output logic [`EXEC_XLEN-1:0] write_data_o,
    output logic                  write_enable_o,
    output logic                  misaligned_o
);
    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0]   address;
    logic [1:0]              offset;
    logic                    is_load;
    logic                    is_store;
    logic                    is_half;
    logic                    is_word;
    logic                    misaligned;
    logic [`EXEC_XLEN/8-1:0] lanes;

    assign address = a_i + b_i;
    assign offset  = address[1:0];

    ////////////////////
    // Access decode
    ////////////////////

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        lanes    = '0;
        case (op_i)
            OP_LB, OP_LBU: is_load = 1'b1;
            OP_LH, OP_LHU: begin
                is_load = 1'b1;
                is_half = 1'b1;
            end
            OP_LW: begin
                is_load = 1'b1;
                is_word = 1'b1;
            end
            OP_SB: begin
                is_store = 1'b1;
                lanes    = 4'b0001 << offset;
            end
            OP_SH: begin
                is_store = 1'b1;
                is_half  = 1'b1;
                lanes    = 4'b0011 << offset;   // Upper lane lost only when misaligned
            end
            OP_SW: begin
                is_store = 1'b1;
                is_word  = 1'b1;
                lanes    = 4'b1111;
            end
            default: ;
        endcase
    end

    assign misaligned = (is_half && offset[0]) || (is_word && (offset != 2'b00));

    ////////////////////
    // Request and store path
    ////////////////////

    always_comb begin
        req_o.read         = enable_i && is_load && !misaligned;
        req_o.read_address = address;
        req_o.write_strobe = (enable_i && is_store && !misaligned) ? lanes : '0;
    end

    assign write_address_o = {address[`EXEC_XLEN-1:2], 2'b00};
    assign write_data_o    = data_i << {offset, 3'b000};   // Move to the addressed lane
    assign write_enable_o  = is_load;
    assign misaligned_o    = enable_i && misaligned;

    read_xor_write: assert final ((enable_i !== 1'b1) || (req_o.read !== 1'b1)
                                  || (req_o.write_strobe === '0))
        else $error("lsu_unit: read and strobe %b both set", req_o.write_strobe);

endmodule

`default_nettype wire

//--- hw/branch_unit.sv
`default_nettype none

`include "exec_settings.svh"

module branch_unit (
    input  logic [`EXEC_XLEN-1:0] a_i,
    input  logic [`EXEC_XLEN-1:0] b_i,
    input  logic [`EXEC_XLEN-1:0] offset_i,
    input  logic [`EXEC_XLEN-1:0] pc_i,
    input  exec_pkg::exec_op_e    op_i,
    output logic [`EXEC_XLEN-1:0] link_o,
    output logic [`EXEC_XLEN-1:0] target_o,
    output logic                  jump_o,
    output logic                  write_enable_o
);
    import exec_pkg::*;

    logic                  equal;
    logic                  less_signed;
    logic                  less_unsigned;
    logic                  is_jump;
    logic [`EXEC_XLEN-1:0] pc_target;
    logic [`EXEC_XLEN-1:0] reg_target;

    ////////////////////
    // Condition flags
    ////////////////////

    assign equal         = a_i == b_i;
    assign less_signed   = $signed(a_i) < $signed(b_i);
    assign less_unsigned = a_i < b_i;
    assign is_jump       = (op_i == OP_JAL) || (op_i == OP_JALR);

    always_comb begin
        case (op_i)
            OP_BEQ:  jump_o = equal;
            OP_BNE:  jump_o = !equal;
            OP_BLT:  jump_o = less_signed;
            OP_BGE:  jump_o = !less_signed;
            OP_BLTU: jump_o = less_unsigned;
            OP_BGEU: jump_o = !less_unsigned;
            default: jump_o = is_jump;         // JAL and JALR always taken
        endcase
    end

    ////////////////////
    // Link and target
    ////////////////////

    assign pc_target  = pc_i + offset_i;
    assign reg_target = a_i + offset_i;

    assign link_o         = pc_i + `EXEC_LINK_OFFSET;
    assign target_o       = (op_i == OP_JALR) ? {reg_target[`EXEC_XLEN-1:1], 1'b0}
                                              : pc_target;
    assign write_enable_o = is_jump;           // Only jumps write the link register

    jalr_aligned: assert final ((op_i !== OP_JALR) || (target_o[0] === 1'b0))
        else $error("branch_unit: JALR target %h has bit 0 set", target_o);

endmodule

`default_nettype wire

//--- hw/shift_unit.sv
`default_nettype none

`include "exec_settings.svh"

module shift_unit (
    input  logic [`EXEC_XLEN-1:0] a_i,
    input  logic [4:0]            shamt_i,  // Low bits of the second operand
    input  exec_pkg::exec_op_e    op_i,
    output logic [`EXEC_XLEN-1:0] result_o
);
    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0] left;
    logic [`EXEC_XLEN-1:0] right_logic;
    logic [`EXEC_XLEN-1:0] right_arith;

    assign left        = a_i << shamt_i;
    assign right_logic = a_i >> shamt_i;
    assign right_arith = $unsigned($signed(a_i) >>> shamt_i);   // Sign bit fills from the top

    always_comb begin
        case (op_i)
            OP_SLL:  result_o = left;
            OP_SRL:  result_o = right_logic;
            OP_SRA:  result_o = right_arith;
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/alu_unit.sv
`default_nettype none

`include "exec_settings.svh"

module alu_unit (
    input  logic [`EXEC_XLEN-1:0] a_i,
    input  logic [`EXEC_XLEN-1:0] b_i,
    input  exec_pkg::exec_op_e    op_i,
    output logic [`EXEC_XLEN-1:0] result_o
);
    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0] sum;
    logic [`EXEC_XLEN-1:0] diff;
    logic                  lt_signed;
    logic                  lt_unsigned;

    ////////////////////
    // Arithmetic and compare
    ////////////////////

    assign sum         = a_i + b_i;
    assign diff        = a_i - b_i;
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    ////////////////////
    // Result select
    ////////////////////

    always_comb begin
        case (op_i)
            OP_ADD:  result_o = sum;
            OP_SUB:  result_o = diff;
            OP_SLT:  result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};   // Zero-extended flag
            OP_SLTU: result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
            OP_XOR:  result_o = a_i ^ b_i;
            OP_OR:   result_o = a_i | b_i;
            OP_AND:  result_o = a_i & b_i;
            default: result_o = '0;                                    // Code 7 has no ALU op
        endcase
    end

    // Valid operands must come with a defined operation code
    op_known: assert final ($isunknown({a_i, b_i}) || !$isunknown(op_i))
        else $error("alu_unit: op_i unknown with operands a=%h b=%h", a_i, b_i);

endmodule

`default_nettype wire

//--- hw/exec_pkg.sv
`default_nettype none

`include "exec_settings.svh"

package exec_pkg;

    ////////////////////
    // Operation encoding
    ////////////////////

    typedef enum logic [2:0] {
        ALU_UNIT    = 3'd0,
        SHIFT_UNIT  = 3'd1,
        BRANCH_UNIT = 3'd2,
        MEMORY_UNIT = 3'd3,
        BYPASS_UNIT = 3'd4,
        CSR_UNIT    = 3'd5                  // Reserved, handled as bypass
    } exec_unit_e;

    // Raw sub-operation code, meaning set by the unit selector
    typedef enum logic [2:0] {
        OP_CODE0, OP_CODE1, OP_CODE2, OP_CODE3,
        OP_CODE4, OP_CODE5, OP_CODE6, OP_CODE7
    } exec_op_e;

    localparam exec_op_e OP_ADD  = OP_CODE0;   // ALU
    localparam exec_op_e OP_SUB  = OP_CODE1;
    localparam exec_op_e OP_SLT  = OP_CODE2;
    localparam exec_op_e OP_SLTU = OP_CODE3;
    localparam exec_op_e OP_XOR  = OP_CODE4;
    localparam exec_op_e OP_OR   = OP_CODE5;
    localparam exec_op_e OP_AND  = OP_CODE6;

    localparam exec_op_e OP_SLL  = OP_CODE0;   // Shifter
    localparam exec_op_e OP_SRL  = OP_CODE1;
    localparam exec_op_e OP_SRA  = OP_CODE2;

    localparam exec_op_e OP_BEQ  = OP_CODE0;   // Branch unit
    localparam exec_op_e OP_BNE  = OP_CODE1;
    localparam exec_op_e OP_BLT  = OP_CODE2;
    localparam exec_op_e OP_BGE  = OP_CODE3;
    localparam exec_op_e OP_BLTU = OP_CODE4;
    localparam exec_op_e OP_BGEU = OP_CODE5;
    localparam exec_op_e OP_JAL  = OP_CODE6;
    localparam exec_op_e OP_JALR = OP_CODE7;

    localparam exec_op_e OP_LB   = OP_CODE0;   // Load/store unit
    localparam exec_op_e OP_LH   = OP_CODE1;
    localparam exec_op_e OP_LW   = OP_CODE2;
    localparam exec_op_e OP_LBU  = OP_CODE3;
    localparam exec_op_e OP_LHU  = OP_CODE4;
    localparam exec_op_e OP_SB   = OP_CODE5;
    localparam exec_op_e OP_SH   = OP_CODE6;
    localparam exec_op_e OP_SW   = OP_CODE7;

    ////////////////////
    // Stage payloads
    ////////////////////

    typedef struct packed {
        exec_unit_e unit;
        exec_op_e   op;
    } iop_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]  instruction;
        logic [`EXEC_XLEN-1:0]  pc;
        logic [`EXEC_XLEN-1:0]  first_op;
        logic [`EXEC_XLEN-1:0]  second_op;
        logic [`EXEC_XLEN-1:0]  third_op;   // Branch offset or store data
        iop_t                   iop;
        logic [`EXEC_TAG_W-1:0] tag;
        logic                   predicted_branch;
        logic                   exception;
    } exec_in_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0]  instruction;
        logic [`EXEC_XLEN-1:0]  pc;
        iop_t                   iop;
        logic [`EXEC_TAG_W-1:0] tag;
        logic                   predicted_branch;
        logic                   exception;
        logic [`EXEC_XLEN-1:0]  result0;
        logic [`EXEC_XLEN-1:0]  result1;
        logic                   jump;
        logic                   write_enable;
    } exec_out_t;

    typedef struct packed {
        logic                     read;
        logic [`EXEC_XLEN-1:0]    read_address;
        logic [`EXEC_XLEN/8-1:0]  write_strobe;  // One bit per byte lane
    } mem_req_t;

endpackage

`default_nettype wire

//--- hw/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

////////////////////
// Data path
////////////////////

`define EXEC_XLEN        32             // Integer register width
`define EXEC_TAG_W       3              // Instruction tag width

////////////////////
// Fixed constants
////////////////////

`define EXEC_RESET_PC    32'h0000_0000  // PC field after reset
`define EXEC_LINK_OFFSET 32'd4          // Return address step

`endif
